//--- vlog.f
+incdir+.
dcache_pkg.sv
ahb_pkg.sv
dcache_line_if.sv
dcache_line.sv
dcache_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock.sv
dcache_sva.sv
dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module dcache_tb -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "sim passed"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

	localparam int num_req = 300;
	// two bursts, each beat with up to three wait states
	localparam int op_budget = 2 * 16 * 4 + 8;

	logic clk;
	logic nrst;
	logic [31:0] dbus_addr;
	logic [3:0] dbus_byteenable;
	logic dbus_read;
	logic dbus_write;
	logic dbus_hitwriteback;
	logic dbus_hitinvalidate;
	logic [31:0] dbus_wrdata;
	logic [31:0] dbus_rddata;
	logic dbus_stall;
	logic [31:0] ahb_haddr;
	logic [2:0] ahb_hburst;
	logic [3:0] ahb_hprot;
	logic [2:0] ahb_hsize;
	ahb_pkg::htrans_t ahb_htrans;
	logic ahb_hwrite;
	logic ahb_hsel;
	logic [31:0] ahb_hwdata;
	logic ahb_hready_in;
	logic [31:0] ahb_hrdata;
	logic ahb_hready_out;
	logic ahb_hresp;

	integer seed;
	logic [31:0] mem [4096];
	logic [31:0] model [4096];

	// slave data phase and burst bookkeeping
	logic dp_pend;
	logic dp_write;
	logic [11:0] dp_addr;
	int waits;
	int wr_bursts;
	int rd_bursts;
	logic [31:0] wr_base;
	logic [31:0] rd_base;

	tb_clock clk_gen (.clk(clk));

	dcache_top dut0 (.*);

	function automatic logic [31:0] fill_word(input logic [11:0] a);
		return {4'ha, a, ~a[7:0], a[11:4]};
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	always @(posedge clk) begin
		check_word("ahb_hready_in", 32'(ahb_hready_in), 32'(ahb_hready_out));
		if (!nrst) begin
			dp_pend = 1'b0;
		end else if (ahb_hready_out) begin
			if (dp_pend && dp_write)
				mem[dp_addr] = ahb_hwdata;
			if (ahb_hsel && ahb_htrans[1]) begin
				assert (ahb_haddr[31:14] == 18'd0)
				else stop_run("bus address outside the test memory");
				// incr16, word size, privileged data access
				check_word("ahb_hburst", 32'(ahb_hburst), 32'h7);
				check_word("ahb_hsize", 32'(ahb_hsize), 32'h2);
				check_word("ahb_hprot", 32'(ahb_hprot), 32'h3);
				dp_pend = 1'b1;
				dp_write = ahb_hwrite;
				dp_addr = ahb_haddr[13:2];
				if (ahb_htrans == ahb_pkg::HTRANS_NONSEQ && ahb_hwrite) begin
					wr_bursts++;
					wr_base = ahb_haddr;
				end else if (ahb_htrans == ahb_pkg::HTRANS_NONSEQ) begin
					rd_bursts++;
					rd_base = ahb_haddr;
				end
			end else begin
				dp_pend = 1'b0;
			end
		end
	end

	// random wait states, at most three in a row
	always @(negedge clk) begin
		logic [31:0] r;
		r = $random(seed);
		if (dp_pend && waits < 3 && r[1:0] == 2'd0) begin
			ahb_hready_out = 1'b0;
			waits++;
		end else begin
			ahb_hready_out = 1'b1;
			waits = 0;
		end
		ahb_hrdata = (dp_pend && !dp_write) ? mem[dp_addr] : 32'h0;
	end

	// caller is at a falling edge, returns at the falling edge after acceptance
	task automatic issue(input logic [31:0] addr, input logic [3:0] cmd,
			input logic [31:0] wdata, input logic [3:0] be);
		wr_bursts = 0;
		rd_bursts = 0;
		dbus_addr = addr;
		dbus_read = cmd[0];
		dbus_write = cmd[1];
		dbus_hitwriteback = cmd[2];
		dbus_hitinvalidate = cmd[3];
		dbus_wrdata = wdata;
		dbus_byteenable = be;
		#1;
		while (dbus_stall) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		dbus_read = 1'b0;
		dbus_write = 1'b0;
		dbus_hitwriteback = 1'b0;
		dbus_hitinvalidate = 1'b0;
	endtask

	task automatic check_line(input logic [11:0] base);
		for (int w = 0; w < 16; w++)
			check_word($sformatf("mem[%h]", base + 12'(w)), mem[base + 12'(w)],
				model[base + 12'(w)]);
	endtask

	// an evicted or cleaned line must match the model in memory
	task automatic check_written_line();
		if (wr_bursts > 0)
			check_line(wr_base[13:2]);
	endtask

	task automatic read_check(input logic [31:0] addr);
		issue(addr, 4'b0001, 32'h0, 4'h0);
		check_word("dbus_rddata", dbus_rddata, model[addr[13:2]]);
		check_written_line();
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] mask;
		seed = 12;
		waits = 0;
		dp_pend = 1'b0;
		dp_write = 1'b0;
		dp_addr = '0;
		wr_bursts = 0;
		rd_bursts = 0;
		nrst = 1'b0;
		dbus_addr = '0;
		dbus_byteenable = '0;
		dbus_read = 1'b0;
		dbus_write = 1'b0;
		dbus_hitwriteback = 1'b0;
		dbus_hitinvalidate = 1'b0;
		dbus_wrdata = '0;
		ahb_hrdata = '0;
		ahb_hready_out = 1'b1;
		ahb_hresp = 1'b0;
		for (int a = 0; a < 4096; a++) begin
			mem[a] = fill_word(12'(a));
			model[a] = fill_word(12'(a));
		end

		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		repeat (3) @(negedge clk);
		assert (ahb_htrans == ahb_pkg::HTRANS_IDLE && !ahb_hsel && !dbus_stall)
		else stop_run("bus or stall not idle after reset");
		assert (wr_bursts == 0 && rd_bursts == 0)
		else stop_run("bus transfer before any request");

		for (int i = 0; i < num_req; i++) begin
			r = $random(seed);
			// 4 tags over 4 indices
			addr = {18'd0, r[1:0], 4'd0, r[3:2], r[7:4], 2'b00};
			wdata = $random(seed);
			case (r[15:8] % 10)
				0, 1, 2, 3, 4: begin
					read_check(addr);
				end
				5, 6, 7: begin
					issue(addr, 4'b0010, wdata, r[19:16]);
					mask = {{8{r[19]}}, {8{r[18]}}, {8{r[17]}}, {8{r[16]}}};
					model[addr[13:2]] = (model[addr[13:2]] & ~mask) | (wdata & mask);
					check_written_line();
				end
				8: begin
					issue(addr, 4'b0100, 32'h0, 4'h0);
					// memory holds the line whether it was dirty, clean or absent
					check_line({addr[13:6], 4'd0});
					issue(addr, 4'b0100, 32'h0, 4'h0);
					assert (wr_bursts == 0)
					else stop_run("second hit-writeback of a clean line wrote to the bus");
				end
				default: begin
					issue(addr, 4'b1000, 32'h0, 4'h0);
					check_line({addr[13:6], 4'd0});
					read_check(addr);
					assert (rd_bursts > 0 && rd_base == {addr[31:6], 6'd0})
					else stop_run("read after hit-invalidate did not fetch the line");
				end
			endcase
		end

		$display("sim passed");
		$finish;
	end

	initial begin
		#(longint'(2 * num_req + 10) * op_budget * 8);
		stop_run("timeout, a request never completed");
	end

endmodule

//--- dcache_sva.sv
`timescale 1ns/1ps

module dcache_sva (
	input logic             clk,
	input logic             nrst,
	input logic [31:0]      ahb_haddr,
	input ahb_pkg::htrans_t ahb_htrans,
	input logic             ahb_hwrite,
	input logic             ahb_hsel,
	input logic [31:0]      ahb_hwdata,
	input logic             ahb_hready_out,
	input logic             dbus_stall
);

	logic [4:0] beats;
	logic accepted;

	assign accepted = ahb_hsel && ahb_htrans[1] && ahb_hready_out;

	// accepted address phases of the current burst
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst)
			beats <= '0;
		else if (accepted && ahb_htrans == ahb_pkg::HTRANS_NONSEQ)
			beats <= 5'd1;
		else if (accepted)
			beats <= beats + 5'd1;
	end

	nonseq_aligned: assert property (@(posedge clk) disable iff (!nrst)
		ahb_htrans == ahb_pkg::HTRANS_NONSEQ |-> ahb_haddr[5:0] == 6'd0)
		else $error("burst start not line aligned");

	seq_advance: assert property (@(posedge clk) disable iff (!nrst)
		accepted |=> (ahb_htrans != ahb_pkg::HTRANS_SEQ) || (ahb_haddr == $past(ahb_haddr) + 32'd4))
		else $error("seq beat does not advance by one word");

	seq_in_burst: assert property (@(posedge clk) disable iff (!nrst)
		ahb_htrans == ahb_pkg::HTRANS_SEQ |-> beats >= 5'd1 && beats < 5'd16)
		else $error("seq beat outside a 16 beat burst");

	burst_length: assert property (@(posedge clk) disable iff (!nrst)
		$fell(ahb_hsel) |-> beats == 5'd16)
		else $error("burst did not have 16 beats");

	wait_hold: assert property (@(posedge clk) disable iff (!nrst)
		ahb_hsel && !ahb_hready_out |=>
			$stable(ahb_haddr) && $stable(ahb_htrans) && $stable(ahb_hwrite) && $stable(ahb_hwdata))
		else $error("bus outputs changed during a wait state");

	stall_on_bus: assert property (@(posedge clk) disable iff (!nrst)
		ahb_hsel |-> dbus_stall)
		else $error("stall low while the bus is selected");

endmodule

bind dcache_top dcache_sva sva0 (.*);

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
	input  logic                 clk,
	input  logic                 nrst,

	// cpu data port
	input  logic [31:0]          dbus_addr,
	input  dcache_pkg::byte_en_t dbus_byteenable,
	input  logic                 dbus_read,
	input  logic                 dbus_write,
	input  logic                 dbus_hitwriteback,
	input  logic                 dbus_hitinvalidate,
	input  dcache_pkg::word_t    dbus_wrdata,
	output dcache_pkg::word_t    dbus_rddata,
	output logic                 dbus_stall,

	// ahb-lite master
	output logic [31:0]          ahb_haddr,
	output ahb_pkg::hburst_t     ahb_hburst,
	output ahb_pkg::hprot_t      ahb_hprot,
	output ahb_pkg::hsize_t      ahb_hsize,
	output ahb_pkg::htrans_t     ahb_htrans,
	output logic                 ahb_hwrite,
	output logic                 ahb_hsel,
	output dcache_pkg::word_t    ahb_hwdata,
	output logic                 ahb_hready_in,
	input  dcache_pkg::word_t    ahb_hrdata,
	input  logic                 ahb_hready_out,
	// error responses are not handled
	input  logic                 ahb_hresp
);

	dcache_line_if lif ();

	assign ahb_hburst = ahb_pkg::HBURST_INCR16;
	assign ahb_hsize = ahb_pkg::HSIZE_WORD;
	assign ahb_hprot = ahb_pkg::HPROT_DATA;
	assign ahb_hready_in = ahb_hready_out;

	dcache_ctrl u_ctrl (
		.clk                (clk),
		.nrst               (nrst),
		.dbus_addr          (dbus_addr),
		.dbus_byteenable    (dbus_byteenable),
		.dbus_read          (dbus_read),
		.dbus_write         (dbus_write),
		.dbus_hitwriteback  (dbus_hitwriteback),
		.dbus_hitinvalidate (dbus_hitinvalidate),
		.dbus_wrdata        (dbus_wrdata),
		.dbus_stall         (dbus_stall),
		.dbus_rddata        (dbus_rddata),
		.ahb_hrdata         (ahb_hrdata),
		.ahb_hready_out     (ahb_hready_out),
		.ahb_haddr          (ahb_haddr),
		.ahb_htrans         (ahb_htrans),
		.ahb_hwrite         (ahb_hwrite),
		.ahb_hsel           (ahb_hsel),
		.ahb_hwdata         (ahb_hwdata),
		.lif                (lif.ctrl)
	);

	dcache_store u_store (
		.clk  (clk),
		.nrst (nrst),
		.lif  (lif.store)
	);

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic [31:0]          dbus_addr,
	input  dcache_pkg::byte_en_t dbus_byteenable,
	input  logic                 dbus_read,
	input  logic                 dbus_write,
	input  logic                 dbus_hitwriteback,
	input  logic                 dbus_hitinvalidate,
	input  dcache_pkg::word_t    dbus_wrdata,
	output logic                 dbus_stall,
	output dcache_pkg::word_t    dbus_rddata,
	input  dcache_pkg::word_t    ahb_hrdata,
	input  logic                 ahb_hready_out,
	output logic [31:0]          ahb_haddr,
	output ahb_pkg::htrans_t     ahb_htrans,
	output logic                 ahb_hwrite,
	output logic                 ahb_hsel,
	output dcache_pkg::word_t    ahb_hwdata,
	dcache_line_if.ctrl          lif
);

	localparam dcache_pkg::offset_t last_off = dcache_pkg::offset_t'(`DCACHE_LINE_WORDS - 1);

	dcache_pkg::ctrl_state_t state;

	dcache_pkg::tag_t cpu_tag;
	dcache_pkg::index_t cpu_idx;
	dcache_pkg::offset_t cpu_off;

	// tag of the line on the bus, old tag on writeback, new one on fill
	dcache_pkg::tag_t mem_tag;
	dcache_pkg::offset_t bus_off;
	dcache_pkg::offset_t store_off;

	dcache_pkg::word_t hwdata_q;
	logic use_hold;

	logic tag_match;
	logic hit;
	logic need_writeback;
	logic need_memread;
	logic need_invalidate;

	assign {cpu_tag, cpu_idx, cpu_off} = dbus_addr[31:2];

	// cpu keeps the address stable while stalled
	assign lif.rd_idx = cpu_idx;
	assign lif.rd_off = (state == dcache_pkg::ST_IDLE) ? cpu_off : store_off;

	assign tag_match = lif.rd_tag == cpu_tag;
	assign hit = lif.rd_valid && tag_match;

	assign need_writeback = lif.rd_valid && lif.rd_dirty && (
		((dbus_read || dbus_write) && !tag_match) ||
		((dbus_hitwriteback || dbus_hitinvalidate) && tag_match)
	);
	assign need_memread = (dbus_read || dbus_write) && !hit;
	assign need_invalidate = dbus_hitinvalidate && hit;

	assign dbus_stall = (state != dcache_pkg::ST_IDLE) || need_writeback || need_memread;
	assign dbus_rddata = lif.rd_data;

	assign ahb_haddr = {mem_tag, cpu_idx, bus_off, 2'b00};

	// store word is fresh only after a cycle with hready high
	assign ahb_hwdata = use_hold ? hwdata_q : lif.rd_data;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= dcache_pkg::ST_IDLE;
			ahb_htrans <= ahb_pkg::HTRANS_IDLE;
			ahb_hwrite <= 1'b0;
			ahb_hsel <= 1'b0;
			lif.wr_en <= 1'b0;
			bus_off <= '0;
			store_off <= '0;
			use_hold <= 1'b0;
		end else begin
			use_hold <= !ahb_hready_out;
			lif.wr_en <= 1'b0;

			case (state)
				dcache_pkg::ST_IDLE: begin
					if (need_writeback) begin
						state <= dcache_pkg::ST_WRITEBACK_FIRST;
						ahb_htrans <= ahb_pkg::HTRANS_NONSEQ;
						ahb_hwrite <= 1'b1;
						ahb_hsel <= 1'b1;
						bus_off <= '0;
						store_off <= '0;
					end else if (need_memread) begin
						state <= dcache_pkg::ST_MEMREAD_FIRST;
						ahb_htrans <= ahb_pkg::HTRANS_NONSEQ;
						ahb_hwrite <= 1'b0;
						ahb_hsel <= 1'b1;
						bus_off <= '0;
						// trails the bus by one, first beat has no data
						store_off <= '1;
					end else if (dbus_write || need_invalidate) begin
						state <= dcache_pkg::ST_WAIT_WRITE;
						lif.wr_en <= 1'b1;
					end
				end

				dcache_pkg::ST_WRITEBACK_FIRST, dcache_pkg::ST_MEMREAD_FIRST: begin
					if (ahb_hready_out) begin
						bus_off <= bus_off + 1'b1;
						store_off <= store_off + 1'b1;
						ahb_htrans <= ahb_pkg::HTRANS_SEQ;
						state <= ahb_hwrite ? dcache_pkg::ST_WRITEBACK : dcache_pkg::ST_MEMREAD;
					end
				end

				dcache_pkg::ST_WRITEBACK: begin
					if (ahb_hready_out) begin
						if (bus_off == '0) begin
							// last data phase done, clean the line
							ahb_hsel <= 1'b0;
							lif.wr_en <= 1'b1;
							state <= dcache_pkg::ST_WAIT_WRITE;
						end else begin
							if (bus_off == last_off) begin
								ahb_htrans <= ahb_pkg::HTRANS_IDLE;
								ahb_hwrite <= 1'b0;
							end
							bus_off <= bus_off + 1'b1;
							store_off <= store_off + 1'b1;
						end
					end
				end

				dcache_pkg::ST_MEMREAD: begin
					if (ahb_hready_out) begin
						lif.wr_en <= 1'b1;
						if (bus_off == '0) begin
							ahb_hsel <= 1'b0;
							state <= dcache_pkg::ST_WAIT_WRITE;
						end else begin
							if (bus_off == last_off)
								ahb_htrans <= ahb_pkg::HTRANS_IDLE;
							bus_off <= bus_off + 1'b1;
							store_off <= store_off + 1'b1;
						end
					end
				end

				dcache_pkg::ST_WAIT_WRITE: begin
					state <= dcache_pkg::ST_IDLE;
				end

				default: begin
					state <= dcache_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// write payload, only consumed while wr_en is high
	always_ff @(posedge clk) begin
		hwdata_q <= ahb_hwdata;

		case (state)
			dcache_pkg::ST_IDLE: begin
				mem_tag <= need_writeback ? lif.rd_tag : cpu_tag;
				lif.wr_idx <= cpu_idx;
				lif.wr_off <= cpu_off;
				lif.wr_tag <= lif.rd_tag;
				lif.wr_data <= dbus_wrdata;
				lif.wr_byte_en <= dbus_write ? dbus_byteenable : '0;
				lif.wr_dirty <= dbus_write;
				lif.wr_valid <= !dbus_hitinvalidate;
			end

			dcache_pkg::ST_WRITEBACK: begin
				lif.wr_tag <= mem_tag;
				lif.wr_byte_en <= '0;
				lif.wr_dirty <= 1'b0;
				lif.wr_valid <= 1'b1;
			end

			dcache_pkg::ST_MEMREAD: begin
				if (ahb_hready_out) begin
					lif.wr_off <= store_off;
					lif.wr_tag <= mem_tag;
					lif.wr_data <= ahb_hrdata;
					lif.wr_byte_en <= '1;
					lif.wr_dirty <= 1'b0;
					// line turns valid with its last word
					lif.wr_valid <= (bus_off == '0);
				end
			end

			default: begin
			end
		endcase
	end

endmodule

//--- dcache_store.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_store (
	input logic clk,
	input logic nrst,
	dcache_line_if.store lif
);

	dcache_pkg::tag_t tags [`DCACHE_NUM_LINES];
	dcache_pkg::word_t words [`DCACHE_NUM_LINES];
	logic [`DCACHE_NUM_LINES-1:0] valids;
	logic [`DCACHE_NUM_LINES-1:0] dirties;
	logic [`DCACHE_NUM_LINES-1:0] line_wr;
	dcache_pkg::index_t rd_idx_q;

	for (genvar i = 0; i < `DCACHE_NUM_LINES; i++) begin : g_line
		assign line_wr[i] = lif.wr_en && (lif.wr_idx == dcache_pkg::index_t'(i));

		dcache_line u_line (
			.clk        (clk),
			.nrst       (nrst),
			.wr_en      (line_wr[i]),
			.wr_tag     (lif.wr_tag),
			.wr_off     (lif.wr_off),
			.wr_data    (lif.wr_data),
			.wr_byte_en (lif.wr_byte_en),
			.wr_dirty   (lif.wr_dirty),
			.wr_valid   (lif.wr_valid),
			.rd_off     (lif.rd_off),
			.tag        (tags[i]),
			.valid      (valids[i]),
			.dirty      (dirties[i]),
			.rd_data    (words[i])
		);
	end

	// every line registers its word, pick the one addressed last cycle
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst)
			rd_idx_q <= '0;
		else
			rd_idx_q <= lif.rd_idx;
	end

	assign lif.rd_tag = tags[lif.rd_idx];
	assign lif.rd_valid = valids[lif.rd_idx];
	assign lif.rd_dirty = dirties[lif.rd_idx];
	assign lif.rd_data = words[rd_idx_q];

endmodule

//--- dcache_line.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_line (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 wr_en,
	input  dcache_pkg::tag_t     wr_tag,
	input  dcache_pkg::offset_t  wr_off,
	input  dcache_pkg::word_t    wr_data,
	input  dcache_pkg::byte_en_t wr_byte_en,
	input  logic                 wr_dirty,
	input  logic                 wr_valid,
	input  dcache_pkg::offset_t  rd_off,
	output dcache_pkg::tag_t     tag,
	output logic                 valid,
	output logic                 dirty,
	output dcache_pkg::word_t    rd_data
);

	dcache_pkg::word_t words [`DCACHE_LINE_WORDS];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			valid <= 1'b0;
			dirty <= 1'b0;
		end else if (wr_en) begin
			valid <= wr_valid;
			dirty <= wr_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag <= wr_tag;
			// metadata-only update when the mask is zero
			for (int b = 0; b < $bits(dcache_pkg::byte_en_t); b++) begin
				if (wr_byte_en[b])
					words[wr_off][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
		rd_data <= words[rd_off];
	end

endmodule

//--- dcache_line_if.sv
`timescale 1ns/1ps

interface dcache_line_if;

	// read side, metadata combinational, data one cycle late
	dcache_pkg::index_t rd_idx;
	dcache_pkg::offset_t rd_off;
	dcache_pkg::tag_t rd_tag;
	logic rd_valid;
	logic rd_dirty;
	dcache_pkg::word_t rd_data;

	// write side
	logic wr_en;
	dcache_pkg::index_t wr_idx;
	dcache_pkg::offset_t wr_off;
	dcache_pkg::tag_t wr_tag;
	dcache_pkg::word_t wr_data;
	dcache_pkg::byte_en_t wr_byte_en;
	logic wr_dirty;
	logic wr_valid;

	modport ctrl (
		output rd_idx, rd_off,
		input  rd_tag, rd_valid, rd_dirty, rd_data,
		output wr_en, wr_idx, wr_off, wr_tag, wr_data, wr_byte_en, wr_dirty, wr_valid
	);

	modport store (
		input  rd_idx, rd_off,
		output rd_tag, rd_valid, rd_dirty, rd_data,
		input  wr_en, wr_idx, wr_off, wr_tag, wr_data, wr_byte_en, wr_dirty, wr_valid
	);

endinterface

//--- ahb_pkg.sv
package ahb_pkg;

	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

	typedef logic [2:0] hburst_t;
	typedef logic [2:0] hsize_t;
	typedef logic [3:0] hprot_t;

	// 16-beat incrementing burst of words, one line
	localparam hburst_t HBURST_INCR16 = 3'b111;
	localparam hsize_t HSIZE_WORD = 3'b010;
	// data access, privileged
	localparam hprot_t HPROT_DATA = 4'b0011;

endpackage

//--- dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

	typedef logic [`DCACHE_TAG_WIDTH-1:0] tag_t;
	typedef logic [`DCACHE_INDEX_WIDTH-1:0] index_t;
	typedef logic [`DCACHE_OFFSET_WIDTH-1:0] offset_t;

	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_en_t;

	// first states only carry the nonseq address phase
	typedef enum logic [2:0] {
		ST_IDLE            = 3'd0,
		ST_WRITEBACK_FIRST = 3'd1,
		ST_WRITEBACK       = 3'd3,
		ST_MEMREAD_FIRST   = 3'd4,
		ST_MEMREAD         = 3'd5,
		ST_WAIT_WRITE      = 3'd6
	} ctrl_state_t;

endpackage

//--- dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address split: tag | index | word offset | byte
`define DCACHE_TAG_WIDTH 20
`define DCACHE_INDEX_WIDTH 6
`define DCACHE_OFFSET_WIDTH 4

// 64 lines of 16 words, 4 KiB total
`define DCACHE_NUM_LINES 64
`define DCACHE_LINE_WORDS 16

`endif
